//--- include/rank_defs.svh
`ifndef RANK_DEFS_SVH
`define RANK_DEFS_SVH

// Data path sizes.
`define SAMPLE_W 8
`define WIN_LEN 5
`define RANK_W 3

// Register map on a 1-bit address.
`define REG_RANK_ADDR 1'b0
`define REG_CTRL_ADDR 1'b1

`endif

//--- design/rank_pkg.sv
`include "rank_defs.svh"

package rank_pkg;

  typedef logic [`SAMPLE_W-1:0] sample_t;

  // s_oldest is the first sample of the window to have arrived.
  typedef struct packed {
    sample_t s_oldest;
    sample_t s_old;
    sample_t s_centre;
    sample_t s_new;
    sample_t s_newest;
  } window_t;

  typedef struct packed {
    sample_t min;
    sample_t q2;
    sample_t mid;
    sample_t q4;
    sample_t max;
  } sorted5_t;

  typedef enum logic [`RANK_W-1:0] {
    RANK_MIN = 3'd0,
    RANK_Q2  = 3'd1,
    RANK_MID = 3'd2,
    RANK_Q4  = 3'd3,
    RANK_MAX = 3'd4
  } rank_e;

  typedef struct packed {
    rank_e rank;
    logic  bypass;
  } filt_cfg_t;

endpackage

//--- design/sort3_net.sv
`timescale 1ns/1ps

module sort3_net
  import rank_pkg::*;
(
  input  sample_t a_i,
  input  sample_t b_i,
  input  sample_t c_i,
  output sample_t max_o,
  output sample_t med_o,
  output sample_t min_o
);

  sample_t ab_hi;
  sample_t ab_lo;
  sample_t rest;

  always_comb begin
    ab_hi = (a_i > b_i) ? a_i : b_i;
    ab_lo = (a_i > b_i) ? b_i : a_i;
    max_o = (ab_hi > c_i) ? ab_hi : c_i;
    rest  = (ab_hi > c_i) ? c_i : ab_hi; // Loser of the second exchange.
    med_o = (rest > ab_lo) ? rest : ab_lo;
    min_o = (rest > ab_lo) ? ab_lo : rest;
  end

endmodule

//--- design/sort5_pipe.sv
`timescale 1ns/1ps

module sort5_pipe
  import rank_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     done_i,
  input  window_t  win_i,
  output logic     done_o,
  output sorted5_t sorted_o
);

  sample_t sn1_max, sn1_med, sn1_min;
  sample_t sn2_max, sn2_med, sn2_min;
  sample_t sn3_max, sn3_med, sn3_min;
  sample_t sn4_max, sn4_med, sn4_min;

  sample_t p1_new, p1_newest, p1_max, p1_med, p1_min;
  sample_t p2_max, p2_med, p2_min, p2_med1, p2_min1;
  sample_t p3_max, p3_med, p3_min, p3_min1, p3_max_o;
  logic    p1_done, p2_done, p3_done;

  // ******************************
  // Stage 1 sorts the three oldest samples.
  // ******************************
  sort3_net sn1 (
    .a_i   (win_i.s_oldest),
    .b_i   (win_i.s_old),
    .c_i   (win_i.s_centre),
    .max_o (sn1_max),
    .med_o (sn1_med),
    .min_o (sn1_min)
  );

  always_ff @(posedge clk) begin
    p1_new    <= win_i.s_new;
    p1_newest <= win_i.s_newest;
    p1_max    <= sn1_max;
    p1_med    <= sn1_med;
    p1_min    <= sn1_min;
  end

  // Stage 2 finds the overall maximum.
  sort3_net sn2 (
    .a_i   (p1_max),
    .b_i   (p1_new),
    .c_i   (p1_newest),
    .max_o (sn2_max),
    .med_o (sn2_med),
    .min_o (sn2_min)
  );

  always_ff @(posedge clk) begin
    p2_max  <= sn2_max;
    p2_med  <= sn2_med;
    p2_min  <= sn2_min;
    p2_med1 <= p1_med;
    p2_min1 <= p1_min;
  end

  sort3_net sn3 (
    .a_i   (p2_med1),
    .b_i   (p2_med),
    .c_i   (p2_min),
    .max_o (sn3_max),
    .med_o (sn3_med),
    .min_o (sn3_min)
  );

  always_ff @(posedge clk) begin
    p3_max   <= sn3_max;  // Fourth rank is settled here.
    p3_med   <= sn3_med;
    p3_min   <= sn3_min;
    p3_min1  <= p2_min1;
    p3_max_o <= p2_max;
  end

  // Stage 4 is combinational off the third register bank.
  sort3_net sn4 (
    .a_i   (p3_min1),
    .b_i   (p3_med),
    .c_i   (p3_min),
    .max_o (sn4_max),
    .med_o (sn4_med),
    .min_o (sn4_min)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p1_done <= 1'b0;
      p2_done <= 1'b0;
      p3_done <= 1'b0;
    end else begin
      p1_done <= done_i;
      p2_done <= p1_done;
      p3_done <= p2_done;
    end
  end

  assign sorted_o = '{min: sn4_min, q2: sn4_med, mid: sn4_max, q4: p3_max, max: p3_max_o};
  assign done_o   = p3_done;

  a_sorted_order : assert property (@(posedge clk) disable iff (!rst_n)
    done_o |-> (sorted_o.min <= sorted_o.q2) && (sorted_o.q2 <= sorted_o.mid) &&
               (sorted_o.mid <= sorted_o.q4) && (sorted_o.q4 <= sorted_o.max));

endmodule

//--- design/sample_window.sv
`timescale 1ns/1ps
`include "rank_defs.svh"

module sample_window
  import rank_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    sample_valid_i,
  input  logic    flush_i,
  input  sample_t sample_i,
  output window_t win_o,
  output logic    win_valid_o
);

  localparam int CNT_W = $clog2(`WIN_LEN + 1);

  logic [CNT_W-1:0] fill_cnt;
  window_t          win_q;

  always_ff @(posedge clk) begin
    if (sample_valid_i) begin
      win_q <= '{s_oldest: win_q.s_old, s_old: win_q.s_centre,
                 s_centre: win_q.s_new, s_new: win_q.s_newest, s_newest: sample_i};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fill_cnt    <= '0;
      win_valid_o <= 1'b0;
    end else if (flush_i) begin
      // A sample arriving with the flush is the first of the new window.
      fill_cnt    <= sample_valid_i ? CNT_W'(1) : '0;
      win_valid_o <= 1'b0;
    end else begin
      if (sample_valid_i && fill_cnt != CNT_W'(`WIN_LEN)) begin
        fill_cnt <= fill_cnt + 1'b1; // Saturates at a full window.
      end
      win_valid_o <= sample_valid_i && (fill_cnt >= CNT_W'(`WIN_LEN - 1));
    end
  end

  assign win_o = win_q;

  a_fill_bound : assert property (@(posedge clk) disable iff (!rst_n)
    fill_cnt <= CNT_W'(`WIN_LEN));

endmodule

//--- design/rank_cfg_regs.sv
`timescale 1ns/1ps
`include "rank_defs.svh"

module rank_cfg_regs
  import rank_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cfg_we_i,
  input  logic       cfg_addr_i,
  input  logic [7:0] cfg_wdata_i,
  output logic [7:0] cfg_rdata_o,
  output filt_cfg_t  cfg_o,
  output logic       flush_o
);

  rank_e rank_q;
  logic  bypass_q;
  logic  flush_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rank_q   <= RANK_MID;
      bypass_q <= 1'b0;
      flush_q  <= 1'b0;
    end else begin
      flush_q <= 1'b0; // Single-cycle pulse.
      if (cfg_we_i) begin
        case (cfg_addr_i)
          `REG_RANK_ADDR: begin
            if (cfg_wdata_i <= 8'(RANK_MAX)) begin
              rank_q <= rank_e'(cfg_wdata_i[`RANK_W-1:0]);
            end
          end
          `REG_CTRL_ADDR: begin
            bypass_q <= cfg_wdata_i[0];
            flush_q  <= cfg_wdata_i[1];
          end
          default: ;
        endcase
      end
    end
  end

  // ******************************
  // Read-back and outputs.
  // ******************************
  always_comb begin
    case (cfg_addr_i)
      `REG_RANK_ADDR: cfg_rdata_o = {{(8 - `RANK_W){1'b0}}, rank_q};
      default:        cfg_rdata_o = {6'b0, 1'b0, bypass_q}; // Flush bit reads zero.
    endcase
  end

  assign cfg_o   = '{rank: rank_q, bypass: bypass_q};
  assign flush_o = flush_q;

  a_rank_legal : assert property (@(posedge clk) disable iff (!rst_n)
    cfg_o.rank <= RANK_MAX);

endmodule

//--- design/rank_out_stage.sv
`timescale 1ns/1ps

module rank_out_stage
  import rank_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      done_i,
  input  sorted5_t  sorted_i,
  input  sample_t   centre_i,
  input  filt_cfg_t cfg_i,
  output sample_t   filt_o,
  output logic      filt_valid_o
);

  sample_t centre_d1, centre_d2, centre_d3;
  sample_t rank_sel;

  // Matches the three register banks of the sorter.
  always_ff @(posedge clk) begin
    centre_d1 <= centre_i;
    centre_d2 <= centre_d1;
    centre_d3 <= centre_d2;
  end

  always_comb begin
    case (cfg_i.rank)
      RANK_MIN: rank_sel = sorted_i.min;
      RANK_Q2:  rank_sel = sorted_i.q2;
      RANK_Q4:  rank_sel = sorted_i.q4;
      RANK_MAX: rank_sel = sorted_i.max;
      default:  rank_sel = sorted_i.mid;
    endcase
  end

  always_ff @(posedge clk) begin
    filt_o <= cfg_i.bypass ? centre_d3 : rank_sel;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      filt_valid_o <= 1'b0;
    end else begin
      filt_valid_o <= done_i;
    end
  end

endmodule

//--- design/rank_filter_top.sv
`timescale 1ns/1ps

module rank_filter_top
  import rank_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sample_valid_i,
  input  sample_t    sample_i,
  input  logic       cfg_we_i,
  input  logic       cfg_addr_i,
  input  logic [7:0] cfg_wdata_i,
  output logic [7:0] cfg_rdata_o,
  output sample_t    filt_o,
  output logic       filt_valid_o
);

  window_t   win;
  logic      win_valid;
  logic      sort_done;
  sorted5_t  sorted;
  filt_cfg_t cfg;
  logic      flush;

  sample_window u_window (
    .clk            (clk),
    .rst_n          (rst_n),
    .sample_valid_i (sample_valid_i),
    .flush_i        (flush),
    .sample_i       (sample_i),
    .win_o          (win),
    .win_valid_o    (win_valid)
  );

  sort5_pipe u_sort (
    .clk      (clk),
    .rst_n    (rst_n),
    .done_i   (win_valid),
    .win_i    (win),
    .done_o   (sort_done),
    .sorted_o (sorted)
  );

  rank_cfg_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .cfg_o       (cfg),
    .flush_o     (flush)
  );

  rank_out_stage u_out (
    .clk          (clk),
    .rst_n        (rst_n),
    .done_i       (sort_done),
    .sorted_i     (sorted),
    .centre_i     (win.s_centre),
    .cfg_i        (cfg),
    .filt_o       (filt_o),
    .filt_valid_o (filt_valid_o)
  );

endmodule

//--- dv/tb_rank_filter.sv
`timescale 1ns/1ps
`include "rank_defs.svh"

module tb_rank_filter
  import rank_pkg::*;
();

  localparam logic [31:0] SEED = 32'h34e5_24e4;
  localparam int RAND_LEN = 40;
  localparam int BURST_LEN = 20;
  localparam int STIM_CYCLES = 5 * RAND_LEN * 4 + 4 * BURST_LEN + 200;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

  typedef struct packed {
    sample_t     value;
    logic [31:0] cyc;
  } exp_t;

  logic       clk;
  logic       rst_n;
  logic       sample_valid_i;
  sample_t    sample_i;
  logic       cfg_we_i;
  logic       cfg_addr_i;
  logic [7:0] cfg_wdata_i;
  logic [7:0] cfg_rdata_o;
  sample_t    filt_o;
  logic       filt_valid_o;

  int          cycle_cnt = 0;
  int          value_errs = 0;
  int          latency_errs = 0;
  int          other_errs = 0;
  logic [31:0] lcg_state = SEED;
  exp_t        exp_q[$];
  window_t     model_win = '0;
  int          model_fill = 0;
  filt_cfg_t   cfg_model = '{rank: RANK_MID, bypass: 1'b0};

  rank_filter_top dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .sample_valid_i (sample_valid_i),
    .sample_i       (sample_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_addr_i     (cfg_addr_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .cfg_rdata_o    (cfg_rdata_o),
    .filt_o         (filt_o),
    .filt_valid_o   (filt_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  always @(posedge clk) begin
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Sorts the window ascending and picks the configured rank.
  function automatic sample_t ref_filter(input window_t w, input filt_cfg_t c);
    sample_t v[5];
    sample_t t;
    v = '{w.s_oldest, w.s_old, w.s_centre, w.s_new, w.s_newest};
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4 - i; j++) begin
        if (v[j] > v[j+1]) begin
          t      = v[j];
          v[j]   = v[j+1];
          v[j+1] = t;
        end
      end
    end
    if (c.bypass) return w.s_centre;
    return v[c.rank];
  endfunction

  task automatic check_sample(input sample_t actual, input sample_t expected, input string what);
    if (actual !== expected) begin
      value_errs++;
      $display("Error at %0t: %s is %02h, expected %02h", $time, what, actual, expected);
    end
  endtask

  task automatic check_reg(input logic [7:0] actual, input logic [7:0] expected,
                           input string what);
    if (actual !== expected) begin
      value_errs++;
      $display("Error at %0t: %s reads %02h, expected %02h", $time, what, actual, expected);
    end
  endtask

  // ******************************
  // Stimulus tasks.
  // ******************************
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      sample_valid_i = 1'b0;
      cfg_we_i       = 1'b0;
    end
  endtask

  task automatic send_sample(input sample_t s);
    @(posedge clk);
    #1;
    sample_valid_i = 1'b1;
    sample_i       = s;
    cfg_we_i       = 1'b0;
    model_win = '{s_oldest: model_win.s_old, s_old: model_win.s_centre,
                  s_centre: model_win.s_new, s_new: model_win.s_newest, s_newest: s};
    if (model_fill < `WIN_LEN) model_fill++;
    if (model_fill == `WIN_LEN) begin
      exp_q.push_back('{value: ref_filter(model_win, cfg_model), cyc: 32'(cycle_cnt + 5)});
    end
  endtask

  task automatic write_reg(input logic addr, input logic [7:0] data);
    @(posedge clk);
    #1;
    sample_valid_i = 1'b0;
    cfg_we_i       = 1'b1;
    cfg_addr_i     = addr;
    cfg_wdata_i    = data;
    if (addr == `REG_RANK_ADDR && data <= 8'd4) cfg_model.rank = rank_e'(data[2:0]);
    if (addr == `REG_CTRL_ADDR) begin
      cfg_model.bypass = data[0];
      if (data[1]) model_fill = 0; // The sample after the write starts a new window.
    end
  endtask

  task automatic read_check(input logic addr, input logic [7:0] expected, input string what);
    @(posedge clk);
    #1;
    sample_valid_i = 1'b0;
    cfg_we_i       = 1'b0;
    cfg_addr_i     = addr;
    @(negedge clk);
    check_reg(cfg_rdata_o, expected, what);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 40) begin
      idle_cycles(1);
      waited++;
    end
    idle_cycles(1);
  endtask

  task automatic send_burst(input int n);
    repeat (n) send_sample(sample_t'(next_rand() >> 24));
    idle_cycles(1);
  endtask

  // Each result is checked at the falling edge of its cycle.
  always @(negedge clk) begin
    exp_t e;
    if (rst_n && filt_valid_o) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("Output %02h at %0t appeared with no result pending", filt_o, $time);
      end else begin
        e = exp_q.pop_front();
        check_sample(filt_o, e.value, "filt_o");
        if (cycle_cnt != int'(e.cyc)) begin
          latency_errs++;
          $display("Error at %0t: result in cycle %0d, expected cycle %0d",
                   $time, cycle_cnt, e.cyc);
        end
      end
    end
  end

  // ******************************
  // Test sequence.
  // ******************************
  initial begin
    rst_n          = 1'b0;
    sample_valid_i = 1'b0;
    sample_i       = '0;
    cfg_we_i       = 1'b0;
    cfg_addr_i     = 1'b0;
    cfg_wdata_i    = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    read_check(`REG_RANK_ADDR, 8'd2, "rank after reset");
    read_check(`REG_CTRL_ADDR, 8'd0, "control after reset");
    send_burst(5); // Only the fifth sample yields a median.
    wait_drain();

    for (int r = 0; r < 5; r++) begin
      write_reg(`REG_RANK_ADDR, 8'(r));
      read_check(`REG_RANK_ADDR, 8'(r), "rank read-back");
      repeat (RAND_LEN) begin
        send_sample(sample_t'(next_rand() >> 24));
        idle_cycles(int'(next_rand() >> 30));
      end
      wait_drain();
    end

    write_reg(`REG_RANK_ADDR, 8'd2);
    send_burst(BURST_LEN); // One result per cycle.
    wait_drain();

    write_reg(`REG_RANK_ADDR, 8'd3);
    write_reg(`REG_RANK_ADDR, 8'd5);
    read_check(`REG_RANK_ADDR, 8'd3, "rank after writing 5");
    write_reg(`REG_RANK_ADDR, 8'd7);
    read_check(`REG_RANK_ADDR, 8'd3, "rank after writing 7");
    write_reg(`REG_CTRL_ADDR, 8'h01);
    read_check(`REG_CTRL_ADDR, 8'h01, "bypass read-back");
    send_burst(BURST_LEN);
    wait_drain();
    write_reg(`REG_CTRL_ADDR, 8'h00);

    send_burst(8);
    write_reg(`REG_CTRL_ADDR, 8'h02); // Flush while results are still in flight.
    read_check(`REG_CTRL_ADDR, 8'h00, "flush bit read-back");
    send_burst(4);
    send_burst(6);
    wait_drain();
    idle_cycles(8);

    if (exp_q.size() != 0) begin
      other_errs++;
      $display("%0d expected results never arrived", exp_q.size());
    end
    $display("Errors: %0d value, %0d latency, %0d other", value_errs, latency_errs, other_errs);
    if (value_errs + latency_errs + other_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+include
design/rank_pkg.sv
design/sort3_net.sv
design/sort5_pipe.sv
design/sample_window.sv
design/rank_cfg_regs.sv
design/rank_out_stage.sv
design/rank_filter_top.sv
dv/tb_rank_filter.sv
